// ==== Makefile ====
# Verilator build and run for the MRAM I2C slave testbench

VERILATOR ?= verilator
TOP       ?= tb_mram_i2c_slave
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Test failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== i2c_bus_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_bus_monitor (
    input  logic FPGA_clk,
    input  logic FPGA_rst,
    input  logic scl,
    input  logic sda,
    output logic scl_rise,
    output logic sda_bit,
    output logic start_det,
    output logic stop_det
);

    // Stages 0 and 1 synchronize, stage 2 keeps the previous level
    logic [2:0] scl_sr;
    logic [2:0] sda_sr;
    logic       scl_steady_high;

    // Idle bus is high on both lines
    always_ff @(posedge FPGA_clk) begin
        if (FPGA_rst) begin
            scl_sr <= 3'b111;
            sda_sr <= 3'b111;
        end else begin
            scl_sr <= {scl_sr[1:0], scl};
            sda_sr <= {sda_sr[1:0], sda};
        end
    end

    ////////////////////
    // Edge and condition decode
    ////////////////////

    assign scl_steady_high = (scl_sr == 3'b111);

    assign scl_rise = (scl_sr[2:1] == 2'b01);

    // Same stage as the SCL edge, so a bit is sampled in step with scl_rise
    assign sda_bit = sda_sr[1];

    // SDA falling with SCL high opens a transfer
    assign start_det = scl_steady_high && (sda_sr[2:1] == 2'b10);

    // SDA rising with SCL high closes it
    assign stop_det = scl_steady_high && (sda_sr[2:1] == 2'b01);

endmodule

`default_nettype wire

// ==== i2c_slave_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_fsm #(
    parameter mram_i2c_pkg::slave_addr_t SLAVE_ADDR = '1
) (
    input  logic                    FPGA_clk,
    input  logic                    FPGA_rst,
    input  logic                    scl_rise,
    input  logic                    sda_bit,
    input  logic                    start_det,
    input  logic                    stop_det,
    input  logic                    ser_data_input,
    input  logic                    last_word,
    input  logic                    hdr_read,
    output logic                    sda_pull_low,
    output mram_i2c_pkg::i2c_byte_t rx_byte,
    output mram_i2c_pkg::rx_field_e rx_field,
    output logic                    rx_store,
    output logic                    read_active,
    output logic                    word_done,
    output logic                    xfer_clear,
    output mram_i2c_pkg::bit_idx_t  counter_out,
    output logic                    cycle_out
);

    import mram_i2c_pkg::*;

    i2c_state_e state;
    bit_idx_t   bit_cnt;
    i2c_byte_t  shift_reg;
    i2c_byte_t  rx_next;
    rx_field_e  field_sel;
    logic [1:0] addr_cnt;
    logic       data_cnt;
    logic       ack_drive;
    logic       word_last;
    logic       addr_match;

    // Byte as it stands once the current bit is shifted in, MSB first
    assign rx_next    = {shift_reg[6:0], sda_bit};
    assign addr_match = (rx_next[7:3] == SLAVE_ADDR);

    assign counter_out = bit_cnt;
    assign cycle_out   = data_cnt;

    // Read bits go straight out, otherwise only the acknowledge pulls low
    assign sda_pull_low = (state == TX_READ) ? ~ser_data_input : ack_drive;

    always_comb begin
        case (state)
            RX_HEADER: field_sel = FIELD_HEADER;
            RX_ADDR: begin
                case (addr_cnt)
                    2'd0:    field_sel = FIELD_ADDR_LO;
                    2'd1:    field_sel = FIELD_ADDR_MID;
                    default: field_sel = FIELD_ADDR_HI_LEN;
                endcase
            end
            default: field_sel = data_cnt ? FIELD_DATA_HI : FIELD_DATA_LO;
        endcase
    end

    ////////////////////
    // Byte shifter
    ////////////////////

    always_ff @(posedge FPGA_clk) begin
        if (scl_rise) begin
            shift_reg <= rx_next;
            if (bit_cnt == '0) begin
                rx_byte  <= rx_next;
                rx_field <= field_sel;
            end
        end
    end

    ////////////////////
    // Protocol FSM
    ////////////////////

    always_ff @(posedge FPGA_clk) begin
        if (FPGA_rst) begin
            state       <= IDLE;
            bit_cnt     <= 3'd7;
            addr_cnt    <= 2'd0;
            data_cnt    <= 1'b0;
            ack_drive   <= 1'b0;
            word_last   <= 1'b0;
            read_active <= 1'b0;
            rx_store    <= 1'b0;
            word_done   <= 1'b0;
            xfer_clear  <= 1'b0;
        end else begin
            rx_store   <= 1'b0;
            word_done  <= 1'b0;
            xfer_clear <= 1'b0;

            if (stop_det) begin
                state       <= IDLE;
                ack_drive   <= 1'b0;
                read_active <= 1'b0;
                xfer_clear  <= (state != IDLE);
            end else if (start_det) begin
                // A repeated start abandons whatever was in progress
                state       <= RX_HEADER;
                bit_cnt     <= 3'd7;
                addr_cnt    <= 2'd0;
                data_cnt    <= 1'b0;
                ack_drive   <= 1'b0;
                read_active <= 1'b0;
                xfer_clear  <= (state != IDLE);
            end else if (scl_rise) begin
                case (state)
                    RX_HEADER: begin
                        if (bit_cnt == '0) begin
                            state     <= ACK_HEADER;
                            ack_drive <= addr_match;
                            rx_store  <= addr_match;
                        end else begin
                            bit_cnt <= bit_cnt - 1'b1;
                        end
                    end

                    // ack_drive doubles as the address match flag here
                    ACK_HEADER: begin
                        ack_drive <= 1'b0;
                        bit_cnt   <= 3'd7;
                        if (ack_drive) begin
                            state <= RX_ADDR;
                        end else begin
                            state      <= IDLE;
                            xfer_clear <= 1'b1;
                        end
                    end

                    RX_ADDR: begin
                        if (bit_cnt == '0) begin
                            state     <= ACK_ADDR;
                            ack_drive <= 1'b1;
                            rx_store  <= 1'b1;
                            if (addr_cnt == 2'd2) begin
                                read_active <= hdr_read;
                            end
                        end else begin
                            bit_cnt <= bit_cnt - 1'b1;
                        end
                    end

                    ACK_ADDR: begin
                        ack_drive <= 1'b0;
                        bit_cnt   <= 3'd7;
                        data_cnt  <= 1'b0;
                        if (addr_cnt != 2'd2) begin
                            addr_cnt <= addr_cnt + 2'd1;
                            state    <= RX_ADDR;
                        end else if (hdr_read) begin
                            state <= TX_READ;
                        end else begin
                            state <= RX_DATA;
                        end
                    end

                    TX_READ: begin
                        if (bit_cnt == '0) begin
                            state <= RX_MASTER_ACK;
                        end else begin
                            bit_cnt <= bit_cnt - 1'b1;
                        end
                    end

                    // NACK or end of burst after the upper byte ends the read
                    RX_MASTER_ACK: begin
                        bit_cnt   <= 3'd7;
                        data_cnt  <= ~data_cnt;
                        word_done <= data_cnt;
                        if (sda_bit || (data_cnt && last_word)) begin
                            state       <= IDLE;
                            read_active <= 1'b0;
                            xfer_clear  <= 1'b1;
                        end else begin
                            state <= TX_READ;
                        end
                    end

                    RX_DATA: begin
                        if (bit_cnt == '0) begin
                            state     <= ACK_DATA;
                            ack_drive <= 1'b1;
                            rx_store  <= 1'b1;
                            // Count moves right after the write strobe, so latch it now
                            word_last <= last_word;
                        end else begin
                            bit_cnt <= bit_cnt - 1'b1;
                        end
                    end

                    ACK_DATA: begin
                        ack_drive <= 1'b0;
                        bit_cnt   <= 3'd7;
                        data_cnt  <= ~data_cnt;
                        if (data_cnt && word_last) begin
                            state      <= IDLE;
                            xfer_clear <= 1'b1;
                        end else begin
                            state <= RX_DATA;
                        end
                    end

                    default: state <= IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== mram_access_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mram_access_ctrl (
    input  logic                     FPGA_clk,
    input  logic                     FPGA_rst,
    input  mram_i2c_pkg::i2c_byte_t  rx_byte,
    input  mram_i2c_pkg::rx_field_e  rx_field,
    input  logic                     rx_store,
    input  logic                     read_active,
    input  logic                     word_done,
    input  logic                     xfer_clear,
    output logic                     last_word,
    output logic                     hdr_read,
    output mram_i2c_pkg::mram_addr_t mram_addr,
    output mram_i2c_pkg::mram_data_t write_data,
    output logic                     chip_en,
    output logic                     read_en,
    output logic                     write_en,
    output logic                     lb_en,
    output logic                     ub_en,
    output logic                     pts_en
);

    import mram_i2c_pkg::*;

    logic       hdr_rw;
    logic       hdr_lb;
    logic       hdr_ub;
    mram_addr_t base_addr;
    burst_len_t burst_len;
    burst_len_t burst_cnt;
    burst_len_t last_cnt;
    i2c_byte_t  data_lo;
    logic       wr_strobe;
    logic       mram_active;

    ////////////////////
    // Stored fields
    ////////////////////

    always_ff @(posedge FPGA_clk) begin
        if (FPGA_rst) begin
            hdr_rw    <= 1'b0;
            hdr_lb    <= 1'b0;
            hdr_ub    <= 1'b0;
            base_addr <= '0;
            burst_len <= '0;
            wr_strobe <= 1'b0;
        end else begin
            // One clock wide, right after the upper data byte arrives
            wr_strobe <= rx_store && (rx_field == FIELD_DATA_HI);
            if (rx_store && (rx_field == FIELD_HEADER)) begin
                hdr_rw <= rx_byte[HDR_RW_BIT];
                hdr_lb <= rx_byte[HDR_LB_BIT];
                hdr_ub <= rx_byte[HDR_UB_BIT];
            end
            if (rx_store && (rx_field == FIELD_ADDR_LO)) begin
                base_addr[7:0] <= rx_byte;
            end
            if (rx_store && (rx_field == FIELD_ADDR_MID)) begin
                base_addr[15:8] <= rx_byte;
            end
            if (rx_store && (rx_field == FIELD_ADDR_HI_LEN)) begin
                base_addr[19:16] <= rx_byte[3:0];
                burst_len        <= rx_byte[7:4];
            end
        end
    end

    always_ff @(posedge FPGA_clk) begin
        if (rx_store && (rx_field == FIELD_DATA_LO)) begin
            data_lo <= rx_byte;
        end
        if (rx_store && (rx_field == FIELD_DATA_HI)) begin
            write_data <= {rx_byte, data_lo};
        end
    end

    ////////////////////
    // Burst counting
    ////////////////////

    always_ff @(posedge FPGA_clk) begin
        if (FPGA_rst || xfer_clear) begin
            burst_cnt <= '0;
        end else if (wr_strobe || word_done) begin
            burst_cnt <= burst_cnt + 4'd1;
        end
    end

    // Length 0 and 1 both mean a single word
    assign last_cnt  = (burst_len > 4'd1) ? burst_len - 4'd1 : 4'd0;
    assign last_word = (burst_cnt == last_cnt);
    assign hdr_read  = ~hdr_rw;
    assign mram_addr = base_addr + mram_addr_t'(burst_cnt);

    // MRAM enables, all active low except pts_en
    assign mram_active = wr_strobe | read_active;
    assign chip_en     = ~mram_active;
    assign read_en     = ~read_active;
    assign write_en    = ~wr_strobe;
    assign lb_en       = ~(mram_active & hdr_lb);
    assign ub_en       = ~(mram_active & hdr_ub);
    assign pts_en      = read_active;

endmodule

`default_nettype wire

// ==== mram_i2c_pkg.sv ====
`default_nettype none

package mram_i2c_pkg;

    ////////////////////
    // Field widths
    ////////////////////

    typedef logic [4:0]  slave_addr_t;
    typedef logic [7:0]  i2c_byte_t;
    typedef logic [2:0]  bit_idx_t;
    typedef logic [19:0] mram_addr_t;
    typedef logic [15:0] mram_data_t;
    typedef logic [3:0]  burst_len_t;

    // Control bits below the 5-bit slave address in the header byte
    localparam int HDR_RW_BIT = 0;  // 0 read, 1 write
    localparam int HDR_LB_BIT = 1;
    localparam int HDR_UB_BIT = 2;

    ////////////////////
    // Encodings
    ////////////////////

    typedef enum logic [3:0] {
        IDLE,
        RX_HEADER,
        ACK_HEADER,
        RX_ADDR,
        ACK_ADDR,
        TX_READ,
        RX_MASTER_ACK,
        RX_DATA,
        ACK_DATA
    } i2c_state_e;

    // Which register a received byte lands in
    typedef enum logic [2:0] {
        FIELD_HEADER,
        FIELD_ADDR_LO,
        FIELD_ADDR_MID,
        FIELD_ADDR_HI_LEN,
        FIELD_DATA_LO,
        FIELD_DATA_HI
    } rx_field_e;

endpackage

`default_nettype wire

// ==== mram_i2c_slave_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mram_i2c_slave_top #(
    parameter mram_i2c_pkg::slave_addr_t SLAVE_ADDR = '1
) (
    input  logic                     FPGA_clk,
    input  logic                     FPGA_rst,
    input  logic                     scl,
    input  logic                     sda,
    input  logic                     ser_data_input,
    output logic                     sda_pull_low,
    output mram_i2c_pkg::mram_addr_t mram_addr,
    output mram_i2c_pkg::mram_data_t write_data,
    output logic                     chip_en,
    output logic                     read_en,
    output logic                     write_en,
    output logic                     lb_en,
    output logic                     ub_en,
    output logic                     pts_en,
    output logic                     cycle_out,
    output mram_i2c_pkg::bit_idx_t   counter_out
);

    import mram_i2c_pkg::*;

    // Bus monitor to FSM
    logic scl_rise;
    logic sda_bit;
    logic start_det;
    logic stop_det;

    // FSM and access controller
    i2c_byte_t rx_byte;
    rx_field_e rx_field;
    logic      rx_store;
    logic      read_active;
    logic      word_done;
    logic      xfer_clear;
    logic      last_word;
    logic      hdr_read;

    i2c_bus_monitor u_bus_monitor (
        .FPGA_clk  (FPGA_clk),
        .FPGA_rst  (FPGA_rst),
        .scl       (scl),
        .sda       (sda),
        .scl_rise  (scl_rise),
        .sda_bit   (sda_bit),
        .start_det (start_det),
        .stop_det  (stop_det)
    );

    i2c_slave_fsm #(
        .SLAVE_ADDR (SLAVE_ADDR)
    ) u_slave_fsm (
        .FPGA_clk       (FPGA_clk),
        .FPGA_rst       (FPGA_rst),
        .scl_rise       (scl_rise),
        .sda_bit        (sda_bit),
        .start_det      (start_det),
        .stop_det       (stop_det),
        .ser_data_input (ser_data_input),
        .last_word      (last_word),
        .hdr_read       (hdr_read),
        .sda_pull_low   (sda_pull_low),
        .rx_byte        (rx_byte),
        .rx_field       (rx_field),
        .rx_store       (rx_store),
        .read_active    (read_active),
        .word_done      (word_done),
        .xfer_clear     (xfer_clear),
        .counter_out    (counter_out),
        .cycle_out      (cycle_out)
    );

    mram_access_ctrl u_access_ctrl (
        .FPGA_clk    (FPGA_clk),
        .FPGA_rst    (FPGA_rst),
        .rx_byte     (rx_byte),
        .rx_field    (rx_field),
        .rx_store    (rx_store),
        .read_active (read_active),
        .word_done   (word_done),
        .xfer_clear  (xfer_clear),
        .last_word   (last_word),
        .hdr_read    (hdr_read),
        .mram_addr   (mram_addr),
        .write_data  (write_data),
        .chip_en     (chip_en),
        .read_en     (read_en),
        .write_en    (write_en),
        .lb_en       (lb_en),
        .ub_en       (ub_en),
        .pts_en      (pts_en)
    );

endmodule

`default_nettype wire

// ==== sim.f ====
mram_i2c_pkg.sv
i2c_bus_monitor.sv
i2c_slave_fsm.sv
mram_access_ctrl.sv
mram_i2c_slave_top.sv
tb_mram_i2c_slave_asserts.sv
tb_mram_i2c_slave.sv

// ==== tb_mram_i2c_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mram_i2c_slave;

    import mram_i2c_pkg::*;

    localparam int          CLK_PERIOD     = 8;
    localparam int          HALF_SCL       = 16;
    localparam int          TIMEOUT_CYCLES = 40 * 20 * 9 * 32 + 20000;
    localparam slave_addr_t SLAVE_ADDR     = 5'h1F;

    logic       FPGA_clk = 1'b0;
    logic       FPGA_rst = 1'b1;
    logic       scl      = 1'b1;
    logic       sda      = 1'b1;
    logic       ser_data_input;
    logic       sda_pull_low;
    mram_addr_t mram_addr;
    mram_data_t write_data;
    logic       chip_en;
    logic       read_en;
    logic       write_en;
    logic       lb_en;
    logic       ub_en;
    logic       pts_en;
    logic       cycle_out;
    bit_idx_t   counter_out;

    integer     seed      = 32'h76a3;
    int         errors    = 0;
    int         cycle_cnt = 0;
    mram_data_t model [mram_addr_t];
    mram_data_t ser_word;

    // Words as the master sent them, keyed by word address
    mram_data_t sent_words [mram_addr_t];

    // Strobes seen during the current transaction
    mram_addr_t cap_addr [$];
    mram_data_t cap_data [$];
    logic       cap_lb [$];
    logic       cap_ub [$];

    // Bursts written so far, read back later
    mram_addr_t wr_base [$];
    burst_len_t wr_len [$];

    mram_i2c_slave_top #(
        .SLAVE_ADDR (SLAVE_ADDR)
    ) u_dut (
        .FPGA_clk       (FPGA_clk),
        .FPGA_rst       (FPGA_rst),
        .scl            (scl),
        .sda            (sda),
        .ser_data_input (ser_data_input),
        .sda_pull_low   (sda_pull_low),
        .mram_addr      (mram_addr),
        .write_data     (write_data),
        .chip_en        (chip_en),
        .read_en        (read_en),
        .write_en       (write_en),
        .lb_en          (lb_en),
        .ub_en          (ub_en),
        .pts_en         (pts_en),
        .cycle_out      (cycle_out),
        .counter_out    (counter_out)
    );

    always #(CLK_PERIOD / 2) FPGA_clk = ~FPGA_clk;

    ////////////////////
    // MRAM model
    ////////////////////

    // External parallel-to-serial mux is combinational
    always_comb begin
        if (model.exists(mram_addr)) begin
            ser_word = model[mram_addr];
        end else begin
            ser_word = '0;
        end
    end

    assign ser_data_input = ser_word[{cycle_out, counter_out}];

    always @(posedge FPGA_clk) begin
        if (!FPGA_rst && (write_en == 1'b0)) begin
            model[mram_addr] = write_data;
            cap_addr.push_back(mram_addr);
            cap_data.push_back(write_data);
            cap_lb.push_back(lb_en);
            cap_ub.push_back(ub_en);
        end
    end

    always @(posedge FPGA_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: the test sequence did not finish within %0d cycles",
                     TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] next_random();
        next_random = $random(seed);
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge FPGA_clk);
    endtask

    task automatic compare(
        input logic [31:0] actual,
        input logic [31:0] expected,
        input string       what
    );
        if (actual !== expected) begin
            errors++;
            $display("error at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic clear_captures();
        cap_addr.delete();
        cap_data.delete();
        cap_lb.delete();
        cap_ub.delete();
    endtask

    ////////////////////
    // I2C master
    ////////////////////

    // One SCL period with SDA changing only while SCL is low
    task automatic clock_bit(input logic bit_val, output logic pulled);
        wait_cycles(1);
        sda <= bit_val;
        wait_cycles(HALF_SCL - 1);
        pulled = sda_pull_low;
        scl <= 1'b1;
        wait_cycles(HALF_SCL);
        scl <= 1'b0;
    endtask

    task automatic start_cond();
        wait_cycles(HALF_SCL);
        sda <= 1'b0;
        wait_cycles(HALF_SCL);
        scl <= 1'b0;
    endtask

    task automatic stop_cond();
        wait_cycles(1);
        sda <= 1'b0;
        wait_cycles(HALF_SCL - 1);
        scl <= 1'b1;
        wait_cycles(HALF_SCL);
        sda <= 1'b1;
        wait_cycles(HALF_SCL);
    endtask

    task automatic send_byte(input i2c_byte_t value, output logic acked);
        logic pulled;
        for (int i = 7; i >= 0; i--) begin
            clock_bit(value[i], pulled);
        end
        clock_bit(1'b1, acked);
    endtask

    task automatic receive_byte(input logic nack, output i2c_byte_t value);
        logic pulled;
        for (int i = 7; i >= 0; i--) begin
            clock_bit(1'b1, pulled);
            value[i] = ~pulled;
            compare(32'(read_en), 32'd0, "read_en low while reading");
            compare(32'(pts_en), 32'd1, "pts_en high while reading");
        end
        clock_bit(nack, pulled);
    endtask

    // Header, then address low, middle and high nibble with burst length
    task automatic send_opening(
        input logic       is_write,
        input mram_addr_t base,
        input burst_len_t len,
        input logic       lb,
        input logic       ub
    );
        logic acked;
        start_cond();
        send_byte({SLAVE_ADDR, ub, lb, is_write}, acked);
        compare(32'(acked), 32'd1, "header acknowledge");
        send_byte(base[7:0], acked);
        compare(32'(acked), 32'd1, "address byte 0 acknowledge");
        send_byte(base[15:8], acked);
        compare(32'(acked), 32'd1, "address byte 1 acknowledge");
        send_byte({len, base[19:16]}, acked);
        compare(32'(acked), 32'd1, "address byte 2 acknowledge");
    endtask

    ////////////////////
    // Transactions
    ////////////////////

    task automatic write_burst(input burst_len_t len);
        logic [31:0] r;
        mram_addr_t  base;
        mram_addr_t  exp_addr;
        logic        lb;
        logic        ub;
        logic        acked;
        int          words;
        mram_data_t  wdata [16];
        r     = next_random();
        base  = r[19:0];
        lb    = r[20];
        ub    = r[21];
        words = (len > 4'd1) ? int'(len) : 1;
        clear_captures();
        send_opening(1'b1, base, len, lb, ub);
        for (int k = 0; k < words; k++) begin
            r        = next_random();
            wdata[k] = r[15:0];
            exp_addr = base + mram_addr_t'(k);
            sent_words[exp_addr] = wdata[k];
            send_byte(wdata[k][7:0], acked);
            compare(32'(acked), 32'd1, "data low byte acknowledge");
            send_byte(wdata[k][15:8], acked);
            compare(32'(acked), 32'd1, "data high byte acknowledge");
        end
        stop_cond();
        compare(32'(cap_addr.size()), 32'(words), "write strobe count");
        for (int k = 0; k < words && k < cap_addr.size(); k++) begin
            exp_addr = base + mram_addr_t'(k);
            compare(32'(cap_addr[k]), 32'(exp_addr), "write address");
            compare(32'(cap_data[k]), 32'(wdata[k]), "write data");
            compare(32'(cap_lb[k]), 32'(!lb), "lb_en during write strobe");
            compare(32'(cap_ub[k]), 32'(!ub), "ub_en during write strobe");
        end
        wr_base.push_back(base);
        wr_len.push_back(len);
    endtask

    task automatic wrong_header();
        logic [31:0] r;
        logic        acked;
        r = next_random();
        while (r[4:0] == SLAVE_ADDR) begin
            r = next_random();
        end
        clear_captures();
        start_cond();
        send_byte({r[4:0], r[7:5]}, acked);
        compare(32'(acked), 32'd0, "no acknowledge for a wrong address");
        stop_cond();
        compare(32'(cap_addr.size()), 32'd0, "no write strobe for a wrong address");
        compare(32'(chip_en), 32'd1, "chip_en idle after a wrong address");
        compare(32'(read_en), 32'd1, "read_en idle after a wrong address");
    endtask

    task automatic read_burst(input int idx);
        mram_addr_t base;
        mram_addr_t exp_addr;
        burst_len_t len;
        int         words;
        i2c_byte_t  lo;
        i2c_byte_t  hi;
        base  = wr_base[idx];
        len   = wr_len[idx];
        words = (len > 4'd1) ? int'(len) : 1;
        send_opening(1'b0, base, len, 1'b1, 1'b1);
        for (int k = 0; k < words; k++) begin
            receive_byte(1'b0, lo);
            // NACK after the high byte of the last word
            receive_byte(k == words - 1, hi);
            exp_addr = base + mram_addr_t'(k);
            compare(32'({hi, lo}), 32'(sent_words[exp_addr]), "read word");
        end
        stop_cond();
        compare(32'(read_en), 32'd1, "read_en released after read");
        compare(32'(pts_en), 32'd0, "pts_en released after read");
        compare(32'(chip_en), 32'd1, "chip_en released after read");
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        logic [31:0] r;
        int          assert_fails;
        wait_cycles(2);
        FPGA_rst <= 1'b0;
        wait_cycles(2);

        compare(32'(chip_en), 32'd1, "chip_en after reset");
        compare(32'(read_en), 32'd1, "read_en after reset");
        compare(32'(write_en), 32'd1, "write_en after reset");
        compare(32'(lb_en), 32'd1, "lb_en after reset");
        compare(32'(ub_en), 32'd1, "ub_en after reset");
        compare(32'(pts_en), 32'd0, "pts_en after reset");
        compare(32'(sda_pull_low), 32'd0, "sda_pull_low after reset");

        // Alternating single and burst writes
        for (int t = 0; t < 6; t++) begin
            r = next_random();
            write_burst({3'b000, r[0]});
            r = next_random();
            write_burst(4'd2 + burst_len_t'(r % 32'd14));
        end

        for (int t = 0; t < 4; t++) begin
            wrong_header();
            r = next_random();
            write_burst({3'b000, r[0]});
        end

        // Even t picks a single write, odd t a burst
        for (int t = 0; t < 6; t++) begin
            read_burst(2 * t + (t % 2));
        end

        assert_fails = int'(u_dut.u_asserts.fail_count);
        $display("Checks done: %0d check errors, %0d assertion failures", errors, assert_fails);
        if ((errors == 0) && (assert_fails == 0)) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_mram_i2c_slave_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mram_i2c_slave_asserts (
    input logic FPGA_clk,
    input logic FPGA_rst,
    input logic chip_en,
    input logic read_en,
    input logic write_en,
    input logic pts_en
);

    int unsigned fail_count = 0;

    // Read and write never overlap on the MRAM
    rw_exclusive: assert property (
        @(posedge FPGA_clk) disable iff (FPGA_rst) !(!read_en && !write_en)
    ) else begin
        $error("read_en and write_en are low together");
        fail_count++;
    end

    // Any access needs the chip selected
    chip_selected: assert property (
        @(posedge FPGA_clk) disable iff (FPGA_rst) (!read_en || !write_en) |-> !chip_en
    ) else begin
        $error("chip_en is high during an MRAM access");
        fail_count++;
    end

    // Serial read path follows the read enable
    pts_follows_read: assert property (
        @(posedge FPGA_clk) disable iff (FPGA_rst) pts_en == ~read_en
    ) else begin
        $error("pts_en is not the inverse of read_en");
        fail_count++;
    end

endmodule

bind mram_i2c_slave_top tb_mram_i2c_slave_asserts u_asserts (
    .FPGA_clk (FPGA_clk),
    .FPGA_rst (FPGA_rst),
    .chip_en  (chip_en),
    .read_en  (read_en),
    .write_en (write_en),
    .pts_en   (pts_en)
);

`default_nettype wire
